//--- design/ad_capture_pkg.sv
package ad_capture_pkg;

  // ********************
  // Frame layout
  // ********************

  // One conversion result as it leaves the converter over all lanes together
  localparam int FRAME_BITS = 32;

  // The code sits in the upper bits and the status byte trails it
  localparam int CODE_BITS = 24;
  localparam int STATUS_BITS = FRAME_BITS - CODE_BITS;

  typedef struct packed {
    logic [CODE_BITS-1:0]   code;
    logic [STATUS_BITS-1:0] status;
  } frame_fields_t;

  // The same received word read either as a plain vector or split into fields
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    frame_fields_t         fields;
  } frame_word_u;

  // ********************
  // Output stream
  // ********************

  // Code mode sign-extends the 24-bit result and raw mode passes the whole frame
  typedef enum logic {
    MODE_CODE = 1'b0,
    MODE_RAW  = 1'b1
  } out_mode_e;

  // Index wraps at 256 so the consumer can spot a gap or a repeat
  typedef struct packed {
    logic [FRAME_BITS-1:0] word;
    logic [7:0]            index;
  } capture_sample_t;

  // ********************
  // Default build values
  // ********************

  // Two data lanes give 16 serial clock cycles per frame
  localparam int DEF_NUM_SDI = 2;
  // Fast clock cycles per half period of the serial clock
  localparam int DEF_CLK_DIV = 4;
  // Board round trip from clock pin out to data pin in
  localparam int DEF_PHY_DELAY = 18;
  // Samples the consumer may hold at once
  localparam int DEF_CREDITS = 4;

endpackage

//--- design/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer import ad_capture_pkg::*; #(
  parameter int CREDITS = DEF_CREDITS
) (
  input  logic        delay_clk,
  input  logic        arst_n,
  input  logic        enable,
  input  logic [15:0] conv_period,
  input  logic        busy,
  input  logic        credit_return,
  input  logic        frame_done,
  output logic        cnv,
  output logic        read_start
);

  // Wide enough to hold the full credit count
  localparam int CW = $clog2(CREDITS + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CNV,
    S_BUSY,
    S_READ
  } seq_state_e;

  seq_state_e    state;
  logic [15:0]   period_cnt;
  logic          period_hit;
  logic          conv_req;
  logic          cnv_cnt;
  logic [CW-1:0] credits;
  logic          fire;

  // ********************
  // Conversion rate
  // ********************

  // Compare in 17 bits so a period of zero or 0xffff cannot wrap the test
  assign period_hit = enable && (({1'b0, period_cnt} + 17'd1) >= {1'b0, conv_period});

  // A conversion only starts from idle and only when the consumer has room for it
  assign fire = (state == S_IDLE) && conv_req && (credits != '0);

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      conv_req   <= 1'b0;
    end else if (!enable) begin
      period_cnt <= '0;
      conv_req   <= 1'b0;
    end else begin
      if (period_hit) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 16'd1;
      end
      // A request that is due keeps waiting until the FSM can take it
      if (period_hit) begin
        conv_req <= 1'b1;
      end else if (fire) begin
        conv_req <= 1'b0;
      end
    end
  end

  // ********************
  // Credit counter
  // ********************

  // A take and a return in the same cycle cancel out
  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= CW'(CREDITS);
    end else begin
      case ({fire, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // ********************
  // Conversion FSM
  // ********************

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= S_IDLE;
      cnv        <= 1'b0;
      cnv_cnt    <= 1'b0;
      read_start <= 1'b0;
    end else begin
      read_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (fire) begin
            cnv     <= 1'b1;
            cnv_cnt <= 1'b0;
            state   <= S_CNV;
          end
        end
        // Convert stays high for two cycles
        S_CNV: begin
          if (cnv_cnt) begin
            cnv   <= 1'b0;
            state <= S_BUSY;
          end else begin
            cnv_cnt <= 1'b1;
          end
        end
        // Busy is first looked at in the cycle after convert drops
        S_BUSY: begin
          if (!busy) begin
            read_start <= 1'b1;
            state      <= S_READ;
          end
        end
        // The read is over once the capture side has the whole frame
        S_READ: begin
          if (frame_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- design/spi_read_engine.sv
`timescale 1ns/1ps

module spi_read_engine import ad_capture_pkg::*; #(
  parameter int NUM_SDI = DEF_NUM_SDI,
  parameter int CLK_DIV = DEF_CLK_DIV
) (
  input  logic delay_clk,
  input  logic arst_n,
  input  logic read_start,
  output logic spi_cs,
  output logic spi_sclk,
  output logic frame_open
);

  // Each lane carries this many bits, one per serial clock cycle
  localparam int LANE_BITS = FRAME_BITS / NUM_SDI;
  localparam int DW = $clog2(CLK_DIV + 1);
  localparam int BW = $clog2(LANE_BITS + 1);

  typedef enum logic [1:0] {
    R_IDLE,
    R_SHIFT,
    R_TAIL
  } rd_state_e;

  rd_state_e     state;
  logic [DW-1:0] div_cnt;
  logic [BW-1:0] bit_cnt;
  logic          half_tick;

  // Marks the last fast cycle of a serial clock half period
  assign half_tick = (div_cnt == DW'(CLK_DIV - 1));

  // ********************
  // Frame read FSM
  // ********************

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= R_IDLE;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      spi_cs     <= 1'b1;
      spi_sclk   <= 1'b0;
      frame_open <= 1'b0;
    end else begin
      frame_open <= 1'b0;
      case (state)
        R_IDLE: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          // Chip select drops and the capture side is told in the same cycle
          if (read_start) begin
            spi_cs     <= 1'b0;
            frame_open <= 1'b1;
            state      <= R_SHIFT;
          end
        end
        // The clock starts low so the first bit has a full half period to settle
        R_SHIFT: begin
          if (half_tick) begin
            div_cnt <= '0;
            if (!spi_sclk) begin
              spi_sclk <= 1'b1;
            end else begin
              spi_sclk <= 1'b0;
              // Bits are counted on falling edges so the last rise is already out
              if (bit_cnt == BW'(LANE_BITS - 1)) begin
                state <= R_TAIL;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        // Clock held low for one more half period before chip select rises
        R_TAIL: begin
          if (half_tick) begin
            spi_cs <= 1'b1;
            state  <= R_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

//--- design/sdi_echo_capture.sv
`timescale 1ns/1ps

module sdi_echo_capture import ad_capture_pkg::*; #(
  parameter int NUM_SDI   = DEF_NUM_SDI,
  parameter int PHY_DELAY = DEF_PHY_DELAY
) (
  input  logic               delay_clk,
  input  logic               arst_n,
  input  logic               spi_sclk,
  input  logic               frame_open,
  input  logic [NUM_SDI-1:0] sdi,
  output logic               frame_done,
  output frame_word_u        frame
);

  localparam int LANE_BITS = FRAME_BITS / NUM_SDI;
  localparam int BW = $clog2(LANE_BITS + 1);

  // One extra stage past the tap gives the previous value for edge detection
  logic [PHY_DELAY:0]   sclk_dly;
  logic                 echo_sclk;
  logic                 echo_rise;
  logic [BW-1:0]        bit_cnt;
  logic                 last_bit;
  logic [LANE_BITS-1:0] lane_sr  [NUM_SDI];
  logic [LANE_BITS-1:0] lane_nxt [NUM_SDI];
  frame_word_u          frame_nxt;

  // ********************
  // Echo clock replica
  // ********************

  // The local serial clock is held back by the board round trip
  // so it lines up with data coming back on the lanes
  assign echo_sclk = sclk_dly[PHY_DELAY-1];
  assign echo_rise = echo_sclk & ~sclk_dly[PHY_DELAY];

  // Lanes are sampled on the rise of the replica and this one is the last of the frame
  assign last_bit = (bit_cnt == BW'(LANE_BITS - 1));

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_dly   <= '0;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      sclk_dly   <= {sclk_dly[PHY_DELAY-1:0], spi_sclk};
      frame_done <= 1'b0;
      // A new frame always starts counting from zero
      if (frame_open) begin
        bit_cnt <= '0;
      end else if (echo_rise) begin
        if (last_bit) begin
          bit_cnt    <= '0;
          frame_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // ********************
  // Lane assembly
  // ********************

  // Next shift value per lane with lane 0 placed in the top slice of the frame
  always_comb begin
    frame_nxt.raw = '0;
    for (int k = 0; k < NUM_SDI; k++) begin
      lane_nxt[k] = (lane_sr[k] << 1) | LANE_BITS'(sdi[k]);
      frame_nxt.raw[FRAME_BITS-1-k*LANE_BITS -: LANE_BITS] = lane_nxt[k];
    end
  end

  // Every lane shifts in one bit on each rise of the replica clock
  always_ff @(posedge delay_clk) begin
    if (echo_rise) begin
      for (int k = 0; k < NUM_SDI; k++) begin
        lane_sr[k] <= lane_nxt[k];
      end
      // The frame takes the last bit directly from the shift input
      if (last_bit) begin
        frame <= frame_nxt;
      end
    end
  end

endmodule

//--- design/sample_formatter.sv
`timescale 1ns/1ps

module sample_formatter import ad_capture_pkg::*; (
  input  logic            delay_clk,
  input  logic            arst_n,
  input  logic            frame_done,
  input  frame_word_u     frame,
  input  out_mode_e       out_mode,
  output logic            out_valid,
  output capture_sample_t out_sample
);

  logic [7:0]            conv_idx;
  logic [FRAME_BITS-1:0] word_sel;

  // ********************
  // Frame decode
  // ********************

  // Code mode reads the field view and copies the code sign into the top byte
  // Raw mode keeps the status byte so the consumer can inspect it
  always_comb begin
    if (out_mode == MODE_CODE) begin
      word_sel = {{(FRAME_BITS - CODE_BITS){frame.fields.code[CODE_BITS-1]}},
                  frame.fields.code};
    end else begin
      word_sel = frame.raw;
    end
  end

  // ********************
  // Output stage
  // ********************

  // The valid pulse and the running index restart from reset
  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      conv_idx  <= '0;
    end else begin
      out_valid <= frame_done;
      if (frame_done) begin
        conv_idx <= conv_idx + 8'd1;
      end
    end
  end

  // Sample word and index are loaded together one cycle after the frame lands
  always_ff @(posedge delay_clk) begin
    if (frame_done) begin
      out_sample.word  <= word_sel;
      out_sample.index <= conv_idx;
    end
  end

endmodule

//--- design/ad_capture_top.sv
`timescale 1ns/1ps

module ad_capture_top import ad_capture_pkg::*; #(
  parameter int NUM_SDI   = DEF_NUM_SDI,
  parameter int CLK_DIV   = DEF_CLK_DIV,
  parameter int PHY_DELAY = DEF_PHY_DELAY,
  parameter int CREDITS   = DEF_CREDITS
) (
  input  logic               delay_clk,
  input  logic               arst_n,
  input  logic               enable,
  input  logic [15:0]        conv_period,
  input  out_mode_e          out_mode,
  input  logic               busy,
  input  logic [NUM_SDI-1:0] sdi,
  input  logic               credit_return,
  output logic               cnv,
  output logic               spi_cs,
  output logic               spi_sclk,
  output logic               out_valid,
  output capture_sample_t    out_sample
);

  // ********************
  // Internal links
  // ********************

  // Sequencer to read engine
  logic        read_start;
  // Read engine to capture at chip select fall
  logic        frame_open;
  // Capture to formatter and back to the sequencer
  logic        frame_done;
  frame_word_u frame;

  conv_sequencer #(
    .CREDITS(CREDITS)
  ) conv_sequencer_i (
    .delay_clk    (delay_clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .conv_period  (conv_period),
    .busy         (busy),
    .credit_return(credit_return),
    .frame_done   (frame_done),
    .cnv          (cnv),
    .read_start   (read_start)
  );

  spi_read_engine #(
    .NUM_SDI(NUM_SDI),
    .CLK_DIV(CLK_DIV)
  ) spi_read_engine_i (
    .delay_clk (delay_clk),
    .arst_n    (arst_n),
    .read_start(read_start),
    .spi_cs    (spi_cs),
    .spi_sclk  (spi_sclk),
    .frame_open(frame_open)
  );

  // Capture runs off the same serial clock that leaves on the pin
  sdi_echo_capture #(
    .NUM_SDI  (NUM_SDI),
    .PHY_DELAY(PHY_DELAY)
  ) sdi_echo_capture_i (
    .delay_clk (delay_clk),
    .arst_n    (arst_n),
    .spi_sclk  (spi_sclk),
    .frame_open(frame_open),
    .sdi       (sdi),
    .frame_done(frame_done),
    .frame     (frame)
  );

  sample_formatter sample_formatter_i (
    .delay_clk (delay_clk),
    .arst_n    (arst_n),
    .frame_done(frame_done),
    .frame     (frame),
    .out_mode  (out_mode),
    .out_valid (out_valid),
    .out_sample(out_sample)
  );

endmodule

//--- bench/adc_model.sv
`timescale 1ns/1ps

module adc_model import ad_capture_pkg::*; #(
  parameter int NUM_SDI   = DEF_NUM_SDI,
  parameter int PHY_DELAY = DEF_PHY_DELAY
) (
  input  logic                  delay_clk,
  input  logic                  cnv,
  input  logic                  spi_cs,
  input  logic                  spi_sclk,
  output logic                  busy,
  output logic [NUM_SDI-1:0]    sdi,
  output logic                  frame_sent,
  output logic [FRAME_BITS-1:0] sent_frame
);

  localparam int LANE_BITS = FRAME_BITS / NUM_SDI;

  logic                              busy_r = 1'b0;
  logic                              sent_r = 1'b0;
  logic [FRAME_BITS-1:0]             frame_r = '0;
  // Board round trip seen by the lanes, one stage per fast clock cycle
  logic [PHY_DELAY-1:0][NUM_SDI-1:0] lane_pipe = '0;
  logic [NUM_SDI-1:0]                lane_val = '0;
  logic                              cnv_q = 1'b0;
  logic                              cs_q = 1'b1;
  logic                              sclk_q = 1'b0;
  logic                              launch;
  int                                busy_left = 0;
  int                                bit_idx = 0;

  assign busy       = busy_r;
  assign sdi        = lane_pipe[PHY_DELAY-1];
  assign frame_sent = sent_r;
  assign sent_frame = frame_r;

  // Pins are looked at on the falling edge, where the DUT outputs are settled
  always @(negedge delay_clk) begin
    sent_r <= 1'b0;
    launch = 1'b0;
    // A new conversion picks its result and holds busy for a random time
    if (cnv === 1'b1 && !cnv_q) begin
      frame_r   <= $urandom;
      sent_r    <= 1'b1;
      busy_r    <= 1'b1;
      busy_left = 10 + int'($urandom % 21);
    end else if (busy_left > 0) begin
      busy_left = busy_left - 1;
      if (busy_left == 0) begin
        busy_r <= 1'b0;
      end
    end
    // First bit goes out at chip select fall and the rest on falling clock edges
    if (cs_q && spi_cs === 1'b0) begin
      bit_idx = 0;
      launch  = 1'b1;
    end else if (spi_cs === 1'b0 && sclk_q && spi_sclk === 1'b0) begin
      bit_idx = bit_idx + 1;
      launch  = (bit_idx < LANE_BITS);
    end
    // Lane 0 carries the top slice of the frame and every lane sends MSB first
    if (launch) begin
      for (int k = 0; k < NUM_SDI; k++) begin
        lane_val[k] = frame_r[FRAME_BITS - 1 - k * LANE_BITS - bit_idx];
      end
    end
    lane_pipe <= {lane_pipe[PHY_DELAY-2:0], lane_val};
    cnv_q  = cnv;
    cs_q   = spi_cs;
    sclk_q = spi_sclk;
  end

endmodule

//--- bench/ad_capture_checker.sv
`timescale 1ns/1ps

module ad_capture_checker import ad_capture_pkg::*; #(
  parameter int NUM_SDI = DEF_NUM_SDI,
  parameter int CREDITS = DEF_CREDITS
) (
  input  logic                  delay_clk,
  input  logic                  arst_n,
  input  logic                  cnv,
  input  logic                  spi_cs,
  input  logic                  spi_sclk,
  input  logic                  out_valid,
  input  capture_sample_t       out_sample,
  input  out_mode_e             out_mode,
  input  logic                  credit_return,
  input  logic                  frame_sent,
  input  logic [FRAME_BITS-1:0] sent_frame,
  input  int                    test_id,
  output int                    value_errors,
  output int                    protocol_errors,
  output int                    sample_count,
  output int                    in_flight
);

  localparam int LANE_BITS = FRAME_BITS / NUM_SDI;

  // Frames the converter model sent, oldest first
  logic [FRAME_BITS-1:0] sent_q[$];
  logic [FRAME_BITS-1:0] sent_word;
  logic [FRAME_BITS-1:0] exp_word;
  logic [7:0]            exp_index = 8'd0;
  logic                  cnv_q = 1'b0;
  logic                  cs_q = 1'b1;
  logic                  sclk_q = 1'b0;
  int                    convs = 0;
  int                    returns = 0;
  int                    samples = 0;
  int                    cnv_len = 0;
  int                    sclk_rises = 0;
  int                    val_err = 0;
  int                    prot_err = 0;

  assign value_errors    = val_err;
  assign protocol_errors = prot_err;
  assign sample_count    = samples;
  assign in_flight       = convs - samples;

  // ********************
  // Reference model
  // ********************

  // Code mode keeps the upper 24 bits and repeats their sign bit into the top byte
  function automatic logic [FRAME_BITS-1:0] expected_word(input logic [FRAME_BITS-1:0] sent,
                                                          input out_mode_e mode);
    logic [23:0] code;
    code = sent[FRAME_BITS-1 -: 24];
    if (mode == MODE_CODE) begin
      return {{8{code[23]}}, code};
    end
    return sent;
  endfunction

  function automatic string test_label(input int id);
    case (id)
      1:       return "code_mode";
      2:       return "raw_mode";
      3:       return "credit_stall";
      4:       return "frame_timing";
      5:       return "random_period";
      default: return "startup";
    endcase
  endfunction

  // ********************
  // Monitor
  // ********************

  always @(negedge delay_clk) begin
    if (arst_n) begin
      if (frame_sent) begin
        sent_q.push_back(sent_frame);
      end
      if (credit_return) begin
        returns = returns + 1;
      end
      // Each conversion holds one credit until the consumer hands it back
      if (cnv && !cnv_q) begin
        convs = convs + 1;
        if (convs - returns > CREDITS) begin
          prot_err = prot_err + 1;
          $display("In %s, %0d conversions are outstanding but only %0d credits exist",
                   test_label(test_id), convs - returns, CREDITS);
        end
      end
      // Convert pulse width measured in fast clock cycles
      if (cnv) begin
        cnv_len = cnv_len + 1;
      end else if (cnv_q) begin
        if (cnv_len != 2) begin
          prot_err = prot_err + 1;
          $display("Error %s: cnv width expected 2, actual %0d", test_label(test_id), cnv_len);
        end
        cnv_len = 0;
      end
      // Serial clock rises are counted per chip select window
      if (!spi_cs && cs_q) begin
        sclk_rises = 0;
      end else if (!spi_cs && spi_sclk && !sclk_q) begin
        sclk_rises = sclk_rises + 1;
      end else if (spi_cs && !cs_q && sclk_rises != LANE_BITS) begin
        prot_err = prot_err + 1;
        $display("Error %s: sclk rises expected %0d, actual %0d",
                 test_label(test_id), LANE_BITS, sclk_rises);
      end
      if (out_valid) begin
        if (convs == samples || sent_q.size() == 0) begin
          prot_err = prot_err + 1;
          $display("In %s, out_valid pulsed with no conversion in flight", test_label(test_id));
        end else begin
          sent_word = sent_q.pop_front();
          exp_word  = expected_word(sent_word, out_mode);
          if (out_sample.word !== exp_word) begin
            val_err = val_err + 1;
            $display("Error %s: word expected %h, actual %h",
                     test_label(test_id), exp_word, out_sample.word);
          end
          if (out_sample.index !== exp_index) begin
            val_err = val_err + 1;
            $display("Error %s: index expected %0d, actual %0d",
                     test_label(test_id), exp_index, out_sample.index);
          end
          exp_index = exp_index + 8'd1;
          samples   = samples + 1;
        end
      end
    end
    cnv_q  = cnv;
    cs_q   = spi_cs;
    sclk_q = spi_sclk;
  end

endmodule

//--- bench/ad_capture_tb.sv
`timescale 1ns/1ps

module ad_capture_tb import ad_capture_pkg::*; ();

  logic                   delay_clk = 1'b0;
  logic                   arst_n;
  logic                   enable;
  logic [15:0]            conv_period;
  out_mode_e              out_mode;
  logic                   busy;
  logic [DEF_NUM_SDI-1:0] sdi;
  logic                   credit_return = 1'b0;
  logic                   cnv;
  logic                   spi_cs;
  logic                   spi_sclk;
  logic                   out_valid;
  capture_sample_t        out_sample;
  logic                   frame_sent;
  logic [FRAME_BITS-1:0]  sent_frame;
  int                     test_id;
  int                     value_errors;
  int                     protocol_errors;
  int                     sample_count;
  int                     in_flight;
  int                     flow_errors = 0;
  int                     timeouts = 0;
  // The consumer tracks the samples it holds and the wait before the next credit goes back
  logic                   hold_credits = 1'b0;
  int                     pending = 0;
  int                     ret_wait = 0;

  always #4 delay_clk = ~delay_clk;

  ad_capture_top #(
    .NUM_SDI  (DEF_NUM_SDI),
    .CLK_DIV  (DEF_CLK_DIV),
    .PHY_DELAY(DEF_PHY_DELAY),
    .CREDITS  (DEF_CREDITS)
  ) ad_capture_top_i (
    .delay_clk    (delay_clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .conv_period  (conv_period),
    .out_mode     (out_mode),
    .busy         (busy),
    .sdi          (sdi),
    .credit_return(credit_return),
    .cnv          (cnv),
    .spi_cs       (spi_cs),
    .spi_sclk     (spi_sclk),
    .out_valid    (out_valid),
    .out_sample   (out_sample)
  );

  adc_model #(
    .NUM_SDI  (DEF_NUM_SDI),
    .PHY_DELAY(DEF_PHY_DELAY)
  ) adc_model_i (
    .delay_clk (delay_clk),
    .cnv       (cnv),
    .spi_cs    (spi_cs),
    .spi_sclk  (spi_sclk),
    .busy      (busy),
    .sdi       (sdi),
    .frame_sent(frame_sent),
    .sent_frame(sent_frame)
  );

  ad_capture_checker #(
    .NUM_SDI(DEF_NUM_SDI),
    .CREDITS(DEF_CREDITS)
  ) ad_capture_checker_i (
    .delay_clk      (delay_clk),
    .arst_n         (arst_n),
    .cnv            (cnv),
    .spi_cs         (spi_cs),
    .spi_sclk       (spi_sclk),
    .out_valid      (out_valid),
    .out_sample     (out_sample),
    .out_mode       (out_mode),
    .credit_return  (credit_return),
    .frame_sent     (frame_sent),
    .sent_frame     (sent_frame),
    .test_id        (test_id),
    .value_errors   (value_errors),
    .protocol_errors(protocol_errors),
    .sample_count   (sample_count),
    .in_flight      (in_flight)
  );

  // ********************
  // Consumer
  // ********************

  // Takes every sample at once and gives its credit back after a random delay
  always @(negedge delay_clk) begin
    credit_return <= 1'b0;
    if (arst_n) begin
      if (out_valid) begin
        pending = pending + 1;
      end
      if (ret_wait > 0) begin
        ret_wait = ret_wait - 1;
      end else if (pending > 0 && !hold_credits) begin
        credit_return <= 1'b1;
        pending  = pending - 1;
        ret_wait = int'($urandom % 16);
      end
    end
  end

  // ********************
  // Wait helpers
  // ********************

  task automatic wait_samples(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = 1000 + 2000 * (target - sample_count);
    while (sample_count < target && cycles < limit && timeouts == 0) begin
      @(posedge delay_clk);
      cycles = cycles + 1;
    end
    if (sample_count < target && timeouts == 0) begin
      timeouts = timeouts + 1;
      $display("Timeout while waiting for sample %0d, only %0d arrived", target, sample_count);
    end
  endtask

  // Outstanding conversions land and every credit goes back before the next phase
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    repeat (4) @(posedge delay_clk);
    while ((in_flight != 0 || pending != 0) && cycles < 20000 && timeouts == 0) begin
      @(posedge delay_clk);
      cycles = cycles + 1;
    end
    if ((in_flight != 0 || pending != 0) && timeouts == 0) begin
      timeouts = timeouts + 1;
      $display("Timeout while draining, %0d conversions and %0d credits still out",
               in_flight, pending);
    end
    repeat (4) @(posedge delay_clk);
  endtask

  task automatic run_phase(input int id, input out_mode_e mode, input logic [15:0] period,
                           input int count);
    int target;
    target = sample_count + count;
    @(negedge delay_clk);
    test_id     = id;
    out_mode    = mode;
    conv_period = period;
    enable      = 1'b1;
    wait_samples(target);
    @(negedge delay_clk);
    enable = 1'b0;
    wait_drained();
  endtask

  task automatic finish_run();
    int total;
    total = value_errors + protocol_errors + flow_errors + timeouts;
    $display("Totals: value errors %0d, protocol errors %0d, flow errors %0d, timeouts %0d",
             value_errors, protocol_errors, flow_errors, timeouts);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // ********************
  // Stimulus
  // ********************

  initial begin
    int          base;
    out_mode_e   rand_mode;
    logic [15:0] rand_period;
    void'($urandom(55592));
    arst_n      = 1'b0;
    enable      = 1'b0;
    conv_period = 16'd200;
    out_mode    = MODE_CODE;
    test_id     = 0;
    repeat (5) @(posedge delay_clk);
    @(negedge delay_clk);
    arst_n = 1'b1;
    repeat (10) @(negedge delay_clk);

    // Long enough run to see the index wrap past 255
    run_phase(1, MODE_CODE, 16'd200, 260);
    run_phase(2, MODE_RAW, 16'd180, 24);

    // Consumer keeps every credit so the stream must stop after DEF_CREDITS samples
    @(posedge delay_clk);
    hold_credits = 1'b1;
    base = sample_count;
    @(negedge delay_clk);
    test_id     = 3;
    out_mode    = MODE_CODE;
    conv_period = 16'd40;
    enable      = 1'b1;
    wait_samples(base + DEF_CREDITS);
    repeat (800) @(posedge delay_clk);
    if (sample_count != base + DEF_CREDITS) begin
      flow_errors = flow_errors + 1;
      $display("Error credit_stall: samples while held expected %0d, actual %0d",
               base + DEF_CREDITS, sample_count);
    end
    hold_credits = 1'b0;
    wait_samples(base + DEF_CREDITS + 12);
    @(negedge delay_clk);
    enable = 1'b0;
    wait_drained();

    // Single frame and then a quiet stretch where no output may appear
    run_phase(4, MODE_CODE, 16'd100, 1);
    repeat (600) @(negedge delay_clk);

    // Periods shorter than a read make each request wait for the one before it
    for (int r = 0; r < 4; r++) begin
      rand_period = 16'(20 + $urandom % 60);
      rand_mode   = ($urandom % 2 == 0) ? MODE_CODE : MODE_RAW;
      run_phase(5, rand_mode, rand_period, 10);
    end
    finish_run();
  end

endmodule

//--- flist.f
design/ad_capture_pkg.sv
design/conv_sequencer.sv
design/spi_read_engine.sv
design/sdi_echo_capture.sv
design/sample_formatter.sv
design/ad_capture_top.sv
bench/adc_model.sv
bench/ad_capture_checker.sv
bench/ad_capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the capture testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f flist.f \
  --top-module ad_capture_tb \
  -o ad_capture_sim

./obj_dir/ad_capture_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
